// File: sim.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ex_control.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/cdb_mux.sv
verilog/ex_stage.sv
testbench/ex_stage_asserts.sv
testbench/ex_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module ex_stage_tb \
	-Mdir obj_dir \
	-o ex_stage_sim

./obj_dir/ex_stage_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"

// File: testbench/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

	localparam int reset_cycles = 16;
	localparam int random_ops   = 120;
	// Rough length of each test in cycles plus margin
	localparam int total_cycles = reset_cycles + 40 + 40 + 30 + 30 + random_ops * 4 + 40 + 100;

	logic             clk;
	logic             reset;
	pipe_pkg::issue_t issue;
	pipe_pkg::cdb_t   cdb;
	logic             alu_free;
	logic             mult_free;

	// Scoreboard indexed by tag
	isa_pkg::data_t exp_value     [1 << pipe_pkg::tag_width];
	bit             exp_br        [1 << pipe_pkg::tag_width];
	bit             pending       [1 << pipe_pkg::tag_width];
	int             issue_cycle   [1 << pipe_pkg::tag_width];
	int             bcast_cycle   [1 << pipe_pkg::tag_width];
	bit             free_at_bcast [1 << pipe_pkg::tag_width];
	pipe_pkg::tag_t next_tag = '0;
	pipe_pkg::tag_t mon_tag;
	int             outstanding = 0;
	int             cycle = 0;
	int             errors = 0;
	int             checks = 0;

	ex_stage i_ex_stage (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.cdb       (cdb),
		.alu_free  (alu_free),
		.mult_free (mult_free)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic isa_pkg::data_t expected_value(input isa_pkg::alu_op_t op,
			input isa_pkg::data_t a, input isa_pkg::data_t b);
		logic [63:0] full;
		full = 64'(a) * 64'(b);
		case (op)
			isa_pkg::op_add:   return a + b;
			isa_pkg::op_sub:   return a - b;
			isa_pkg::op_and:   return a & b;
			isa_pkg::op_or:    return a | b;
			isa_pkg::op_xor:   return a ^ b;
			isa_pkg::op_cmpeq: return (a == b) ? 32'd1 : 32'd0;
			default:           return full[31:0];
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus monitor sampled mid cycle where cdb is settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset && cdb.valid) begin
			mon_tag = cdb.tag;
			checks++;
			assert (pending[mon_tag]) else begin
				$display("Tag %0d broadcast without an outstanding instruction at %0t",
					mon_tag, $time);
				errors++;
			end
			assert (cdb.value == exp_value[mon_tag]) else begin
				$display("CHECK FAILED t=%0t cdb.value (tag %0d) expected %h got %h",
					$time, mon_tag, exp_value[mon_tag], cdb.value);
				errors++;
			end
			assert (cdb.br_taken == exp_br[mon_tag]) else begin
				$display("CHECK FAILED t=%0t cdb.br_taken (tag %0d) expected %0b got %0b",
					$time, mon_tag, exp_br[mon_tag], cdb.br_taken);
				errors++;
			end
			if (pending[mon_tag]) begin
				outstanding--;
			end
			pending[mon_tag]       = 1'b0;
			bcast_cycle[mon_tag]   = cycle;
			free_at_bcast[mon_tag] = alu_free;
		end
	end

	task automatic check_cycle(input string what, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			$display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, what, expected, actual);
			errors++;
		end
	endtask

	// Drives one strobe once the target unit is free
	task automatic issue_op(input isa_pkg::alu_op_t op, input isa_pkg::data_t a,
			input isa_pkg::data_t b);
		int             waited;
		pipe_pkg::tag_t t;
		waited = 0;
		while (!((op == isa_pkg::op_mul) ? mult_free : alu_free) && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (waited == 20) begin
			$display("Unit never became free for a new instruction at %0t", $time);
			errors++;
		end
		t = next_tag;
		next_tag = next_tag + 1'b1;
		exp_value[t]   = expected_value(op, a, b);
		exp_br[t]      = (op == isa_pkg::op_cmpeq) && (a == b);
		pending[t]     = 1'b1;
		issue_cycle[t] = cycle;
		outstanding++;
		issue = '{valid: 1'b1, op: op, a: a, b: b, tag: t};
		@(posedge clk);
		#2;
		issue.valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Waits for all outstanding results
	task automatic drain(input string name);
		int n;
		n = 0;
		while (outstanding != 0 && n < 20) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (outstanding != 0) begin
			$display("Test %s left %0d results that were never broadcast", name, outstanding);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s done, %0d errors", name, errors - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int               errs_before;
		int               total_errors;
		pipe_pkg::tag_t   t0;
		isa_pkg::alu_op_t op;
		isa_pkg::data_t   a;
		isa_pkg::data_t   b;
		void'($urandom(32'hfac9));
		issue = '0;
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2;
		reset = 1'b0;

		errs_before = errors;
		for (int k = 0; k < 6; k++) begin
			issue_op(isa_pkg::alu_op_t'(3'(k)), $urandom, $urandom);
		end
		drain("alu_ops");
		report_test("alu_ops", errs_before);

		errs_before = errors;
		a = $urandom;
		issue_op(isa_pkg::op_cmpeq, a, a);
		issue_op(isa_pkg::op_cmpeq, a, a + 32'd1);
		issue_op(isa_pkg::op_sub, a, a);
		issue_op(isa_pkg::op_xor, a, ~a);
		issue_op(isa_pkg::op_mul, a, 32'd1);
		drain("branch_flag");
		report_test("branch_flag", errs_before);

		// Three multiplies back to back
		errs_before = errors;
		t0 = next_tag;
		for (int k = 0; k < 3; k++) begin
			issue_op(isa_pkg::op_mul, $urandom, $urandom);
		end
		drain("mult_throughput");
		check_cycle("first product cycle", issue_cycle[t0] + pipe_pkg::mult_stages,
			bcast_cycle[t0]);
		check_cycle("second product cycle", issue_cycle[t0] + pipe_pkg::mult_stages + 1,
			bcast_cycle[t0 + 6'd1]);
		check_cycle("third product cycle", issue_cycle[t0] + pipe_pkg::mult_stages + 2,
			bcast_cycle[t0 + 6'd2]);
		report_test("mult_throughput", errs_before);

		// ALU result ready in the same cycle as a multiply
		errs_before = errors;
		t0 = next_tag;
		issue_op(isa_pkg::op_mul, $urandom, $urandom);
		idle(pipe_pkg::mult_stages - 2);
		issue_op(isa_pkg::op_add, $urandom, $urandom);
		drain("priority_stall");
		check_cycle("multiply broadcast cycle", issue_cycle[t0] + pipe_pkg::mult_stages,
			bcast_cycle[t0]);
		check_cycle("stalled ALU broadcast cycle",
			issue_cycle[t0] + pipe_pkg::mult_stages + 1, bcast_cycle[t0 + 6'd1]);
		check_cycle("alu_free during multiply broadcast", 0, int'(free_at_bcast[t0]));
		report_test("priority_stall", errs_before);

		errs_before = errors;
		for (int k = 0; k < random_ops; k++) begin
			op = isa_pkg::alu_op_t'(3'($urandom_range(6, 0)));
			a  = $urandom;
			b  = ($urandom_range(3, 0) == 0) ? a : $urandom;
			issue_op(op, a, b);
			if ($urandom_range(3, 0) == 0) begin
				idle(1);
			end
		end
		drain("random_stream");
		report_test("random_stream", errs_before);

		total_errors = errors + i_ex_stage.i_ex_stage_asserts.fail_count;
		$display("Tests 5, checks %0d, errors %0d", checks, total_errors);
		if (total_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(total_cycles * 20);
		$display("Watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

// File: testbench/ex_stage_asserts.sv
`timescale 1ns/1ps

module ex_stage_asserts (
	input logic             clk,
	input logic             reset,
	input pipe_pkg::issue_t issue,
	input pipe_pkg::cdb_t   cdb,
	input logic             alu_free,
	input logic             mult_free
);

	int fail_count = 0;

	// Idle bus and open units right after reset
	reset_state: assert property (@(posedge clk)
		$fell(reset) |-> (!cdb.valid && alu_free && mult_free))
	else begin
		$error("Stage not idle after reset");
		fail_count++;
	end

	//////////////////////////////////////////////////////////////////////
	// Issue only into a free unit
	//////////////////////////////////////////////////////////////////////

	mult_target: assert property (@(posedge clk) disable iff (reset)
		(issue.valid && issue.op == isa_pkg::op_mul) |-> mult_free)
	else begin
		$error("Multiply issued while the multiplier was busy");
		fail_count++;
	end

	alu_target: assert property (@(posedge clk) disable iff (reset)
		(issue.valid && issue.op != isa_pkg::op_mul) |-> alu_free)
	else begin
		$error("ALU op issued while the ALU was busy");
		fail_count++;
	end

	// Branch flag only rides on a valid broadcast
	br_with_valid: assert property (@(posedge clk) disable iff (reset)
		cdb.br_taken |-> cdb.valid)
	else begin
		$error("Branch flag high on an idle bus");
		fail_count++;
	end

endmodule

bind ex_stage ex_stage_asserts i_ex_stage_asserts (
	.clk       (clk),
	.reset     (reset),
	.issue     (issue),
	.cdb       (cdb),
	.alu_free  (alu_free),
	.mult_free (mult_free)
);

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input  logic             clk,
	input  logic             reset,
	input  pipe_pkg::issue_t issue,
	output pipe_pkg::cdb_t   cdb,
	output logic             alu_free,
	output logic             mult_free
);

	pipe_pkg::issue_t       alu_issue;
	pipe_pkg::issue_t       mult_issue;
	pipe_pkg::unit_result_t alu_res;
	pipe_pkg::unit_result_t mult_res;
	pipe_pkg::grant_t       grant;

	// Routing and completion arbitration
	ex_control i_ex_control (
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.alu_res    (alu_res),
		.mult_res   (mult_res),
		.alu_issue  (alu_issue),
		.mult_issue (mult_issue),
		.grant      (grant),
		.alu_free   (alu_free),
		.mult_free  (mult_free)
	);

	// Functional units
	alu_unit i_alu_unit (
		.clk       (clk),
		.reset     (reset),
		.alu_issue (alu_issue),
		.grant     (grant),
		.alu_res   (alu_res)
	);

	mult_unit i_mult_unit (
		.clk        (clk),
		.reset      (reset),
		.mult_issue (mult_issue),
		.grant      (grant),
		.mult_res   (mult_res)
	);

	// Result broadcast
	cdb_mux i_cdb_mux (
		.alu_res  (alu_res),
		.mult_res (mult_res),
		.grant    (grant),
		.cdb      (cdb)
	);

endmodule

// File: verilog/cdb_mux.sv
`timescale 1ns/1ps

module cdb_mux (
	input  pipe_pkg::unit_result_t alu_res,
	input  pipe_pkg::unit_result_t mult_res,
	input  pipe_pkg::grant_t       grant,
	output pipe_pkg::cdb_t         cdb
);

	// Granted unit onto the bus or all zero when idle
	always_comb begin
		case (grant)
			pipe_pkg::grant_alu: begin
				cdb.valid    = 1'b1;
				cdb.value    = alu_res.value;
				cdb.tag      = alu_res.tag;
				cdb.br_taken = alu_res.br_taken;
			end
			pipe_pkg::grant_mult: begin
				cdb.valid    = 1'b1;
				cdb.value    = mult_res.value;
				cdb.tag      = mult_res.tag;
				cdb.br_taken = mult_res.br_taken;
			end
			default: cdb = '0;
		endcase
	end

endmodule

// File: verilog/mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  pipe_pkg::issue_t       mult_issue,
	input  pipe_pkg::grant_t       grant,
	output pipe_pkg::unit_result_t mult_res
);

	logic [pipe_pkg::mult_stages-1:0] vld_q;
	pipe_pkg::tag_t                   tag_q  [pipe_pkg::mult_stages];
	isa_pkg::data_t                   prod_q [pipe_pkg::mult_stages];
	isa_pkg::data_t                   a_q    [pipe_pkg::mult_stages-1];
	isa_pkg::data_t                   b_q    [pipe_pkg::mult_stages-1];
	logic                             advance;

	// One slice of the multiplier operand per stage with the low bits kept
	function automatic isa_pkg::data_t mult_step(
		input isa_pkg::data_t acc,
		input isa_pkg::data_t a,
		input isa_pkg::data_t b,
		input int             k
	);
		int             cw;
		isa_pkg::data_t chunk;
		cw    = (isa_pkg::data_width + pipe_pkg::mult_stages - 1) / pipe_pkg::mult_stages;
		chunk = (b >> (k * cw)) & ((isa_pkg::data_t'(1) << cw) - 1'b1);
		return acc + ((a * chunk) << (k * cw));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////////////////////////

	// Freeze everything while a finished product waits for the bus
	assign advance = !vld_q[pipe_pkg::mult_stages-1] || (grant == pipe_pkg::grant_mult);

	always_ff @(posedge clk) begin
		if (reset) begin
			vld_q <= '0;
		end else if (advance) begin
			vld_q <= {vld_q[pipe_pkg::mult_stages-2:0], mult_issue.valid};
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			tag_q[0]  <= mult_issue.tag;
			prod_q[0] <= mult_step('0, mult_issue.a, mult_issue.b, 0);
			a_q[0]    <= mult_issue.a;
			b_q[0]    <= mult_issue.b;
			for (int k = 1; k < pipe_pkg::mult_stages; k++) begin
				tag_q[k]  <= tag_q[k-1];
				prod_q[k] <= mult_step(prod_q[k-1], a_q[k-1], b_q[k-1], k);
			end
			// Operands are needed up to the next to last stage
			for (int k = 1; k < pipe_pkg::mult_stages - 1; k++) begin
				a_q[k] <= a_q[k-1];
				b_q[k] <= b_q[k-1];
			end
		end
	end

	assign mult_res = '{
		ready:    vld_q[pipe_pkg::mult_stages-1],
		value:    prod_q[pipe_pkg::mult_stages-1],
		tag:      tag_q[pipe_pkg::mult_stages-1],
		br_taken: 1'b0
	};

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input  logic                   clk,
	input  logic                   reset,
	input  pipe_pkg::issue_t       alu_issue,
	input  pipe_pkg::grant_t       grant,
	output pipe_pkg::unit_result_t alu_res
);

	isa_pkg::data_t value_d;
	logic           br_d;
	logic           ready_q;
	isa_pkg::data_t value_q;
	pipe_pkg::tag_t tag_q;
	logic           br_q;

	// Integer operations and branch condition
	always_comb begin
		br_d = 1'b0;
		case (alu_issue.op)
			isa_pkg::op_add: value_d = alu_issue.a + alu_issue.b;
			isa_pkg::op_sub: value_d = alu_issue.a - alu_issue.b;
			isa_pkg::op_and: value_d = alu_issue.a & alu_issue.b;
			isa_pkg::op_or:  value_d = alu_issue.a | alu_issue.b;
			isa_pkg::op_xor: value_d = alu_issue.a ^ alu_issue.b;
			isa_pkg::op_cmpeq: begin
				br_d    = (alu_issue.a == alu_issue.b);
				value_d = {{(isa_pkg::data_width-1){1'b0}}, br_d};
			end
			default: value_d = '0;
		endcase
	end

	// Held until the bus takes it
	always_ff @(posedge clk) begin
		if (reset) begin
			ready_q <= 1'b0;
		end else if (alu_issue.valid) begin
			ready_q <= 1'b1;
		end else if (grant == pipe_pkg::grant_alu) begin
			ready_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (alu_issue.valid) begin
			value_q <= value_d;
			tag_q   <= alu_issue.tag;
			br_q    <= br_d;
		end
	end

	assign alu_res = '{ready: ready_q, value: value_q, tag: tag_q, br_taken: br_q};

endmodule

// File: verilog/ex_control.sv
`timescale 1ns/1ps

module ex_control (
	input  logic                   clk,
	input  logic                   reset,
	input  pipe_pkg::issue_t       issue,
	input  pipe_pkg::unit_result_t alu_res,
	input  pipe_pkg::unit_result_t mult_res,
	output pipe_pkg::issue_t       alu_issue,
	output pipe_pkg::issue_t       mult_issue,
	output pipe_pkg::grant_t       grant,
	output logic                   alu_free,
	output logic                   mult_free
);

	isa_pkg::inst_class_t inst_class;
	logic                 alu_seen_q;
	logic                 alu_open;

	//////////////////////////////////////////////////////////////////////
	// Issue routing
	//////////////////////////////////////////////////////////////////////

	// Only multiplies go to the multiplier
	always_comb begin
		if (issue.op == isa_pkg::op_mul) begin
			inst_class = isa_pkg::class_mult;
		end else begin
			inst_class = isa_pkg::class_alu;
		end
	end

	// Last cycle's ALU strobe is still in the result register unless it leaves now
	assign alu_open = !alu_seen_q || (grant == pipe_pkg::grant_alu);

	always_comb begin
		alu_issue        = issue;
		mult_issue       = issue;
		alu_issue.valid  = issue.valid && (inst_class == isa_pkg::class_alu) &&
			alu_free && alu_open;
		mult_issue.valid = issue.valid && (inst_class == isa_pkg::class_mult) && mult_free;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			alu_seen_q <= 1'b0;
		end else begin
			alu_seen_q <= alu_issue.valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Completion arbitration
	//////////////////////////////////////////////////////////////////////

	// Longer unit first
	always_comb begin
		if (mult_res.ready) begin
			grant = pipe_pkg::grant_mult;
		end else if (alu_res.ready) begin
			grant = pipe_pkg::grant_alu;
		end else begin
			grant = pipe_pkg::grant_none;
		end
	end

	// Empty, or its held result goes out this cycle
	assign alu_free  = !alu_res.ready || (grant == pipe_pkg::grant_alu);
	assign mult_free = !mult_res.ready || (grant == pipe_pkg::grant_mult);

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

	// Physical register index width
	localparam int tag_width = 6;

	// Multiplier pipeline depth
	localparam int mult_stages = 3;

	typedef logic [tag_width-1:0] tag_t;

	// Issued instruction, valid for one cycle
	typedef struct packed {
		logic             valid;
		isa_pkg::alu_op_t op;
		isa_pkg::data_t   a;
		isa_pkg::data_t   b;
		tag_t             tag;
	} issue_t;

	// Finished result held by a unit
	typedef struct packed {
		logic           ready;
		isa_pkg::data_t value;
		tag_t           tag;
		logic           br_taken;
	} unit_result_t;

	// Common data bus broadcast
	typedef struct packed {
		logic           valid;
		isa_pkg::data_t value;
		tag_t           tag;
		logic           br_taken;
	} cdb_t;

	typedef enum logic [1:0] {
		grant_none,
		grant_alu,
		grant_mult
	} grant_t;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

	// Operand and result width
	localparam int data_width = 32;

	typedef logic [data_width-1:0] data_t;

	// Operation codes seen by the execute stage
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_cmpeq,
		op_mul
	} alu_op_t;

	// Functional unit class of an instruction
	typedef enum logic {
		class_alu,
		class_mult
	} inst_class_t;

endpackage
